//--- files.f
source/wb_bus_pkg.sv
source/wb_xfer_pkg.sv
source/wb_bus_if.sv
source/wb_xfer_ctrl.sv
source/wb_single_master.sv
source/wb_sram_slave.sv
source/wb_xfer_top.sv
dv/wb_xfer_asserts.sv
dv/wb_xfer_tb.sv

//--- dv/wb_xfer_tb.sv
module wb_xfer_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import wb_bus_pkg::*;

   // ------------------------------------------------------------------
   // Constants.
   // ------------------------------------------------------------------
   localparam int PIPED         = 1;
   localparam int WAIT_STATES   = 2;
   localparam int MEM_DEPTH     = 64;
   localparam int IDX_W         = $clog2(MEM_DEPTH);
   localparam int LAT           = WAIT_STATES + 2;  // Command edge to done cycle.
   localparam int N_RANDOM      = 200;
   localparam int IDLE_TIMEOUT  = 4 * LAT;          // Cycles.
   localparam int DRAIN_TIMEOUT = 4 * LAT;
   localparam logic [31:0] LFSR_SEED = 32'd76355;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1.

   // One expected result, due at the negedge where cyc_cnt is e0 + LAT.
   typedef struct packed {
      logic [31:0] e0;                     // Edge that samples the command.
      logic        done;
      logic        fail;
      dat_t        dat;                    // dat_o from the result cycle on.
   } exp_t;

   logic clk_i;
   logic rst_i;
   logic read_i;
   logic write_i;
   adr_t adr_i;
   dat_t dat_i;
   dat_t dat_o;
   logic busy_o;
   logic done_o;
   logic fail_o;

   dat_t        ref_mem [MEM_DEPTH];       // Reference memory image.
   dat_t        ref_dat;                   // Last word read successfully.
   dat_t        cur_dat;                   // dat_o the monitor expects now.
   exp_t        exp_q [$];                 // Accepted commands, oldest first.
   int unsigned cyc_cnt = 0;               // Rising edges so far.
   logic [31:0] lfsr_state;

   wb_xfer_top #(
      .PIPED       (PIPED),
      .WAIT_STATES (WAIT_STATES),
      .MEM_DEPTH   (MEM_DEPTH)
   ) DUT (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .read_i  (read_i),
      .write_i (write_i),
      .adr_i   (adr_i),
      .dat_i   (dat_i),
      .dat_o   (dat_o),
      .busy_o  (busy_o),
      .done_o  (done_o),
      .fail_o  (fail_o)
   );

   always #4 clk_i = ~clk_i;               // 8 ns period.

   always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

   // ------------------------------------------------------------------
   // Stimulus helpers and reference model.
   // ------------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit, packed LSB last.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Result of one accepted command; updates the memory image.
   function automatic exp_t ref_model(input logic rd, input logic wr, input adr_t adr,
                                      input dat_t dat);
      exp_t e;
      logic in_range;
      in_range = (int'(adr) < MEM_DEPTH);
      e        = '0;
      e.done   = in_range;                 // Out of range ends in err.
      e.fail   = !in_range;
      if (rd && in_range) begin
         ref_dat = ref_mem[adr];           // Read wins over write.
      end else if (!rd && wr && in_range) begin
         ref_mem[adr] = dat;
      end
      e.dat = ref_dat;
      return e;
   endfunction

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_dat(input string name, input dat_t got, input dat_t exp);
      if (got !== exp) begin
         fail_stop($sformatf("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_stop($sformatf("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Called 1 ns after a rising edge; returns at the first such point with busy low.
   task automatic wait_idle();
      int n;
      n = 0;
      while (busy_o) begin
         @(posedge clk_i);
         #1;
         n++;
         if (n > IDLE_TIMEOUT) begin
            fail_stop("Timeout: busy_o stayed high and the transfer never ended");
         end
      end
   endtask

   // Pulses one command at the first free cycle and records its result.
   task automatic send_cmd(input logic rd, input logic wr, input adr_t adr, input dat_t dat);
      exp_t e;
      wait_idle();
      e    = ref_model(rd, wr, adr, dat);
      e.e0 = cyc_cnt + 1;                  // Sampled on the next edge.
      exp_q.push_back(e);
      read_i  = rd;
      write_i = wr;
      adr_i   = adr;
      dat_i   = dat;
      @(posedge clk_i);
      #1;
      read_i  = 1'b0;
      write_i = 1'b0;
   endtask

   // Random commands every cycle while busy; all must be ignored.
   task automatic flood_busy();
      logic [31:0] r;
      int          n;
      n = 0;
      while (busy_o) begin
         r       = rand_bits(2);
         read_i  = r[0];
         write_i = r[1] || !r[0];          // Never an empty pulse.
         adr_i   = adr_t'(rand_bits(ADR_W));
         dat_i   = dat_t'(rand_bits(DAT_W));
         @(posedge clk_i);
         #1;
         n++;
         if (n > IDLE_TIMEOUT) begin
            fail_stop("Timeout: busy_o stayed high while sending ignored commands");
         end
      end
      read_i  = 1'b0;
      write_i = 1'b0;
   endtask

   task automatic read_all();
      int i;
      for (i = 0; i < MEM_DEPTH; i++) begin
         send_cmd(1'b1, 1'b0, adr_t'(i), '0);
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() > 0) begin
         @(negedge clk_i);
         n++;
         if (n > DRAIN_TIMEOUT) begin
            fail_stop("Timeout: an accepted command never produced done or fail");
         end
      end
      repeat (LAT + 2) @(posedge clk_i);  // Quiet window for stray pulses.
   endtask

   // ------------------------------------------------------------------
   // Checking process. Samples at the falling edge.
   // ------------------------------------------------------------------
   always @(negedge clk_i) begin
      exp_t e;
      logic busy_exp;
      if (DUT.u_asserts.fail_cnt != 0) begin
         fail_stop("A protocol assertion failed");
      end
      if (cyc_cnt >= 1) begin
         busy_exp = 1'b0;
         foreach (exp_q[i]) begin
            if (exp_q[i].e0 <= cyc_cnt && cyc_cnt < exp_q[i].e0 + LAT) begin
               busy_exp = 1'b1;
            end
         end
         check_bit("busy_o", busy_o, busy_exp);
         if (exp_q.size() > 0 && exp_q[0].e0 + LAT == cyc_cnt) begin
            e = exp_q.pop_front();
            check_bit("done_o", done_o, e.done);
            check_bit("fail_o", fail_o, e.fail);
            cur_dat = e.dat;
         end else begin
            check_bit("done_o", done_o, 1'b0);  // No result due now.
            check_bit("fail_o", fail_o, 1'b0);
         end
         check_dat("dat_o", dat_o, cur_dat);
      end
   end

   // ------------------------------------------------------------------
   // Test sequence.
   // ------------------------------------------------------------------
   initial begin
      logic [31:0] r;
      adr_t        a;
      int          i;
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      read_i     = 1'b0;
      write_i    = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      lfsr_state = LFSR_SEED;
      ref_dat    = '0;
      cur_dat    = '0;                     // dat_o is zero after reset.
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      for (i = 0; i < MEM_DEPTH; i++) begin  // Fill every word.
         send_cmd(1'b0, 1'b1, adr_t'(i), dat_t'(rand_bits(DAT_W)));
      end
      read_all();

      // Out-of-range accesses after a good read.
      send_cmd(1'b1, 1'b0, adr_t'(5), '0);
      send_cmd(1'b1, 1'b0, adr_t'(MEM_DEPTH), '0);
      send_cmd(1'b0, 1'b1, adr_t'(MEM_DEPTH), dat_t'(rand_bits(DAT_W)));
      send_cmd(1'b0, 1'b1, 8'hFF, dat_t'(rand_bits(DAT_W)));
      send_cmd(1'b1, 1'b1, 8'hC3, dat_t'(rand_bits(DAT_W)));
      read_all();

      for (i = 0; i < 8; i++) begin       // Commands while busy.
         r = rand_bits(1);
         send_cmd(r[0], !r[0], adr_t'(rand_bits(IDX_W)), dat_t'(rand_bits(DAT_W)));
         flood_busy();
      end
      read_all();

      for (i = 0; i < N_RANDOM; i++) begin
         r = rand_bits(3);
         if (r[2]) begin
            a = adr_t'(rand_bits(ADR_W));  // Full range.
         end else begin
            a = adr_t'(rand_bits(IDX_W));  // In range only.
         end
         send_cmd(r[0], r[1] || !r[0], a, dat_t'(rand_bits(DAT_W)));
      end
      drain();

      if (DUT.u_asserts.fail_cnt == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         fail_stop("A protocol assertion failed during the run");
      end
   end

endmodule : wb_xfer_tb

//--- dv/wb_xfer_asserts.sv
module wb_xfer_asserts (
   input logic clk_i,
   input logic rst_i,
   input logic cyc_i,                      // Internal bus cycle.
   input logic stb_i,                      // Internal bus strobe.
   input logic ack_i,
   input logic err_i,
   input logic busy_i,                     // Top-level status outputs.
   input logic done_i,
   input logic fail_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;              // Failed assertions so far.

   // ------------------------------------------------------------------
   // Bus protocol.
   // ------------------------------------------------------------------
   a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
      else begin
         fail_cnt++;
         $error("stb high outside a bus cycle");
      end

   a_ack_err: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
      else begin
         fail_cnt++;
         $error("ack and err high together");
      end

   // ------------------------------------------------------------------
   // Result pulses.
   // ------------------------------------------------------------------
   a_done_fail: assert property (@(posedge clk_i) disable iff (rst_i) !(done_i && fail_i))
      else begin
         fail_cnt++;
         $error("done and fail high together");
      end

   a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
      else begin
         fail_cnt++;
         $error("done longer than one cycle");
      end

   a_fail_pulse: assert property (@(posedge clk_i) disable iff (rst_i) fail_i |=> !fail_i)
      else begin
         fail_cnt++;
         $error("fail longer than one cycle");
      end

   // Reset leaves the master idle.
   a_busy_rst: assert property (@(posedge clk_i) rst_i |=> !busy_i)
      else begin
         fail_cnt++;
         $error("busy high after reset");
      end

endmodule : wb_xfer_asserts

// Attach to every instance of the top level, internal bus included.
bind wb_xfer_top wb_xfer_asserts u_asserts (
   .clk_i  (clk_i),
   .rst_i  (rst_i),
   .cyc_i  (bus.cyc),
   .stb_i  (bus.stb),
   .ack_i  (bus.ack),
   .err_i  (bus.err),
   .busy_i (busy_o),
   .done_i (done_o),
   .fail_i (fail_o)
);

//--- source/wb_xfer_top.sv
module wb_xfer_top #(
   parameter int PIPED       = 1,          // Strobe style of the master.
   parameter int WAIT_STATES = 2,          // Slave latency in wait states.
   parameter int MEM_DEPTH   = 64          // Slave memory size in words.
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             read_i,        // One-cycle read command.
   input  logic             write_i,       // One-cycle write command.
   input  wb_bus_pkg::adr_t adr_i,
   input  wb_bus_pkg::dat_t dat_i,
   output wb_bus_pkg::dat_t dat_o,
   output logic             busy_o,
   output logic             done_o,
   output logic             fail_o
);

   // ------------------------------------------------------------------
   // Internal bus.
   // ------------------------------------------------------------------
   wb_bus_if bus ();

   // Master with its control block.
   wb_single_master #(
      .PIPED      (PIPED)
   ) u_master (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .read_i     (read_i),
      .write_i    (write_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .dat_o      (dat_o),
      .busy_o     (busy_o),
      .done_o     (done_o),
      .fail_o     (fail_o),
      .ctrl_bus_o (bus.ctrl),
      .data_bus_o (bus.data)
   );

   // Memory slave.
   wb_sram_slave #(
      .WAIT_STATES (WAIT_STATES),
      .MEM_DEPTH   (MEM_DEPTH)
   ) u_slave (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bus_i       (bus.slave)
   );

endmodule : wb_xfer_top

//--- source/wb_sram_slave.sv
module wb_sram_slave #(
   parameter int WAIT_STATES = 2,          // Cycles between accept and response.
   parameter int MEM_DEPTH   = 64          // Words; higher addresses give err.
) (
   input  logic     clk_i,
   input  logic     rst_i,
   wb_bus_if.slave  bus_i
);
   import wb_bus_pkg::*;
   import wb_xfer_pkg::*;

   // ------------------------------------------------------------------
   // Sizes.
   // ------------------------------------------------------------------
   localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
   localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'((WAIT_STATES > 0) ? WAIT_STATES - 1 : 0);

   // ------------------------------------------------------------------
   // Internal signals.
   // ------------------------------------------------------------------
   dat_t             mem [MEM_DEPTH];      // Storage.
   slv_state_e       state_q;
   logic [CNT_W-1:0] cnt_q;                // Wait-state counter.
   adr_t             adr_q;                // Recorded request.
   logic             we_q;
   dat_t             dat_q;
   logic             bad_q;                // Address out of range.
   logic [IDX_W-1:0] idx;                  // Memory index.
   logic             req;                  // Request seen on the bus.
   logic             take;                 // Request accepted this edge.
   logic             resp;                 // Response cycle.

   assign req  = bus_i.cyc && bus_i.stb;
   assign take = (state_q == SLV_IDLE) && req;  // Only accept while idle.
   assign resp = (state_q == SLV_RESP);
   assign idx  = adr_q[IDX_W-1:0];

   // ------------------------------------------------------------------
   // Response FSM.
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= SLV_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            SLV_IDLE: begin
               cnt_q <= '0;
               if (req) begin
                  state_q <= (WAIT_STATES == 0) ? SLV_RESP : SLV_DELAY;
               end
            end
            SLV_DELAY: begin
               if (cnt_q == CNT_LAST) begin
                  state_q <= SLV_RESP;     // Last wait state done.
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            SLV_RESP: state_q <= SLV_IDLE; // Exactly one response cycle.
            default:  state_q <= SLV_IDLE;
         endcase
      end
   end

   // Request record, taken on the accept edge.
   always_ff @(posedge clk_i) begin
      if (take) begin
         adr_q <= bus_i.adr;
         we_q  <= bus_i.we;
         dat_q <= bus_i.dat_w;
         bad_q <= (int'(bus_i.adr) >= MEM_DEPTH);
      end
   end

   // Write lands at the end of the ack cycle. Error requests write nothing.
   always_ff @(posedge clk_i) begin
      if (resp && we_q && !bad_q) begin
         mem[idx] <= dat_q;
      end
   end

   // ------------------------------------------------------------------
   // Bus outputs.
   // ------------------------------------------------------------------
   assign bus_i.ack   = resp && !bad_q;
   assign bus_i.err   = resp && bad_q;
   assign bus_i.dat_r = (resp && !bad_q) ? mem[idx] : '0;  // Zero outside ack.

endmodule : wb_sram_slave

//--- source/wb_single_master.sv
module wb_single_master #(
   parameter int PIPED = 1                 // Strobe style, passed to the control block.
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             read_i,
   input  logic             write_i,
   input  wb_bus_pkg::adr_t adr_i,         // Valid with the command pulse.
   input  wb_bus_pkg::dat_t dat_i,         // Write data, valid with the command.
   output wb_bus_pkg::dat_t dat_o,         // Last successful read word.
   output logic             busy_o,
   output logic             done_o,
   output logic             fail_o,
   wb_bus_if.ctrl           ctrl_bus_o,
   wb_bus_if.data           data_bus_o
);
   import wb_bus_pkg::*;

   // ------------------------------------------------------------------
   // Internal signals.
   // ------------------------------------------------------------------
   logic accept;                           // Command taken.
   logic capture;                          // Read data to load.
   adr_t adr_q;                            // Address for the current cycle.
   dat_t wdat_q;                           // Write data for the current cycle.
   dat_t rdat_q;                           // Read data register.

   // Cycle control.
   wb_xfer_ctrl #(
      .PIPED     (PIPED)
   ) u_ctrl (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .read_i    (read_i),
      .write_i   (write_i),
      .bus_o     (ctrl_bus_o),
      .accept_o  (accept),
      .capture_o (capture),
      .busy_o    (busy_o),
      .done_o    (done_o),
      .fail_o    (fail_o)
   );

   // ------------------------------------------------------------------
   // Command latch. Held for the whole bus cycle.
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (accept) begin
         adr_q  <= adr_i;
         wdat_q <= dat_i;                  // Harmless for reads.
      end
   end

   assign data_bus_o.adr   = adr_q;
   assign data_bus_o.dat_w = wdat_q;

   // ------------------------------------------------------------------
   // Read data register.
   // ------------------------------------------------------------------
   // Loads on the ack edge so the word shows together with done.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdat_q <= '0;
      end else if (capture) begin
         rdat_q <= data_bus_o.dat_r;
      end
   end

   assign dat_o = rdat_q;                  // Writes and failures leave it alone.

endmodule : wb_single_master

//--- source/wb_xfer_ctrl.sv
module wb_xfer_ctrl #(
   parameter int PIPED = 1                 // 1: one STB per transfer, 0: hold STB to ACK.
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    read_i,                 // One-cycle read command.
   input  logic    write_i,                // One-cycle write command.
   wb_bus_if.ctrl  bus_o,
   output logic    accept_o,               // Command taken this cycle.
   output logic    capture_o,              // Read data valid on the bus.
   output logic    busy_o,
   output logic    done_o,
   output logic    fail_o
);
   import wb_xfer_pkg::*;

   // ------------------------------------------------------------------
   // Internal signals.
   // ------------------------------------------------------------------
   xfer_state_e state_q;                   // Current control state.
   xfer_state_e state_d;                   // Next control state.
   logic        we_q;                      // Registered write enable.
   logic        done_q;                    // Done pulse register.
   logic        fail_q;                    // Fail pulse register.
   logic        cmd;                       // Any command present.
   logic        req_out;                   // Own request outstanding.
   logic        rsp_ack;                   // Filtered acknowledge.
   logic        rsp_err;                   // Filtered error.
   logic        rsp;                       // Cycle terminates this edge.

   assign cmd     = read_i || write_i;

   // Only count a response while our own request is on the bus.
   assign req_out = (state_q == XFER_STROBE) || (state_q == XFER_WAIT);
   assign rsp_err = req_out && bus_o.err;  // Error takes precedence.
   assign rsp_ack = req_out && bus_o.ack && !bus_o.err;
   assign rsp     = rsp_ack || rsp_err;

   // ------------------------------------------------------------------
   // Next-state logic.
   // ------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         XFER_IDLE: begin
            if (cmd) begin
               state_d = XFER_STROBE;      // CYC and STB rise after this edge.
            end
         end
         XFER_STROBE: begin
            if (rsp) begin
               state_d = XFER_IDLE;        // Response already in.
            end else if (PIPED != 0) begin
               state_d = XFER_WAIT;        // Strobe only once.
            end
         end
         XFER_WAIT: begin
            if (rsp) begin
               state_d = XFER_IDLE;
            end
         end
         default: state_d = XFER_IDLE;
      endcase
   end

   // ------------------------------------------------------------------
   // State, write enable and result registers.
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= XFER_IDLE;
         we_q    <= 1'b0;
         done_q  <= 1'b0;
         fail_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         done_q  <= rsp_ack;               // One-cycle pulse after the ack edge.
         fail_q  <= rsp_err;               // One-cycle pulse after the err edge.
         if (accept_o) begin
            we_q <= write_i && !read_i;    // Read wins over write.
         end else if (rsp) begin
            we_q <= 1'b0;                  // Keep WE low between cycles.
         end
      end
   end

   // Bus control outputs decode straight from the state flops.
   assign bus_o.cyc = req_out;
   assign bus_o.stb = (state_q == XFER_STROBE);
   assign bus_o.we  = we_q;

   // Strobes for the datapath.
   assign accept_o  = (state_q == XFER_IDLE) && cmd;
   assign capture_o = rsp_ack && !we_q;    // Acknowledged read only.

   // Status outputs.
   assign busy_o    = req_out;             // Commands are ignored while high.
   assign done_o    = done_q;
   assign fail_o    = fail_q;

endmodule : wb_xfer_ctrl

//--- source/wb_bus_if.sv
// ----------------------------------------------------------------------
// Point-to-point Wishbone bus between the single master and the slave.
// ----------------------------------------------------------------------
interface wb_bus_if;
   import wb_bus_pkg::*;

   logic cyc;    // Bus cycle in progress.
   logic stb;    // Request strobe.
   logic we;     // Write enable, high for writes.
   adr_t adr;    // Word address.
   dat_t dat_w;  // Master to slave data.
   dat_t dat_r;  // Slave to master data.
   logic ack;    // Normal termination.
   logic err;    // Error termination.

   // Cycle control side of the master.
   modport ctrl (
      output cyc, stb, we,
      input  ack, err
   );

   // Address and data side of the master.
   modport data (
      output adr, dat_w,
      input  dat_r
   );

   // Memory slave.
   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack, err
   );

endinterface : wb_bus_if

//--- source/wb_xfer_pkg.sv
// ----------------------------------------------------------------------
// State encodings for the transfer control FSM and the memory slave.
// ----------------------------------------------------------------------
package wb_xfer_pkg;

   // Master control states.
   typedef enum logic [1:0] {
      XFER_IDLE   = 2'd0,  // No cycle on the bus.
      XFER_STROBE = 2'd1,  // CYC and STB high.
      XFER_WAIT   = 2'd2   // CYC high, STB low, pipelined mode only.
   } xfer_state_e;

   // Slave response states.
   typedef enum logic [1:0] {
      SLV_IDLE  = 2'd0,    // Waiting for a request.
      SLV_DELAY = 2'd1,    // Counting wait states.
      SLV_RESP  = 2'd2     // One cycle of ack or err.
   } slv_state_e;

endpackage : wb_xfer_pkg

//--- source/wb_bus_pkg.sv
// ----------------------------------------------------------------------
// Bus geometry shared by the master, the slave and the bus interface.
// ----------------------------------------------------------------------
package wb_bus_pkg;

   // Address and data widths of the Wishbone bus.
   parameter int ADR_W = 8;   // Byte-free word address.
   parameter int DAT_W = 32;  // One data word per transfer.

   // A word address on the bus.
   typedef logic [ADR_W-1:0] adr_t;

   // A data word, used for both write and read data.
   typedef logic [DAT_W-1:0] dat_t;

endpackage : wb_bus_pkg
